// ==== verification/tlul_memory_stim.txt ====
# opcode size address mask data exp_opcode exp_denied exp_data
# all hex, source id is set per request by the testbench
0 2 00000010 f 11223344 0 0 00000000
4 2 00000010 0 00000000 2 0 11223344
4 0 00000010 0 00000000 2 0 00000011
4 0 00000013 0 00000000 2 0 00000044
4 1 00000010 0 00000000 2 0 00001122
4 1 00000012 0 00000000 2 0 00003344
4 1 00000011 0 00000000 2 0 00002233
0 0 00000011 2 000000aa 0 0 00000000
0 1 00000012 c 0000bbcc 0 0 00000000
4 2 00000010 0 00000000 2 0 11aabbcc
0 0 00000010 3 000000ff 7 1 00000000
0 1 00000010 6 0000ffff 7 1 00000000
0 1 00000010 5 0000ffff 7 1 00000000
0 2 00000010 7 ffffffff 7 1 00000000
4 2 00000010 0 00000000 2 0 11aabbcc
0 2 0000003c f cafef00d 0 0 00000000
4 2 0000003c 0 00000000 2 0 cafef00d
4 0 0000003f 0 00000000 2 0 0000000d
4 0 00000040 0 00000000 7 1 00000000
4 1 0000003f 0 00000000 7 1 00000000
4 2 0000003d 0 00000000 7 1 00000000
0 2 00000040 f 12345678 7 1 00000000
0 1 0000003f 3 00001234 7 1 00000000
4 3 00000000 0 00000000 7 1 00000000
0 3 00000000 f 00000000 7 1 00000000
4 2 ffffffff 0 00000000 7 1 00000000
4 2 0000003c 0 00000000 2 0 cafef00d
1 0 00000020 1 00000077 0 0 00000000
4 0 00000020 0 00000000 2 0 00000077

// ==== src.f ====
logic/tlul_mem_pkg.sv
logic/tlul_request_decode.sv
logic/tlul_mem_array.sv
logic/tlul_response_gen.sv
logic/tlul_memory.sv
verification/tlul_memory_assertions.sv
verification/tlul_memory_tb.sv

// ==== Makefile ====
# Verilator flow for the TileLink-UL memory

VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tlul_memory_tb
FILE_LIST := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tlul_memory_tb.sv ====
////////////////////////////////////////
// TileLink-UL memory testbench
// Replays the stimulus file, checks every D response
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tlul_memory_tb;

    import tlul_mem_pkg::*;

    localparam int    MEM_BYTES = 64;
    localparam int    TIMEOUT   = 200;                                 // Cycles per wait loop
    localparam string STIM_PATH = "verification/tlul_memory_stim.txt";

    logic              clk;
    logic              reset;
    logic              a_valid;
    logic              a_ready;
    tl_opcode_t        a_opcode;
    logic [2:0]        a_param;
    tl_size_t          a_size;
    logic [SID_W-1:0]  a_source;
    logic [XLEN-1:0]   a_address;
    logic [STRB_W-1:0] a_mask;
    logic [XLEN-1:0]   a_data;
    logic              d_valid;
    logic              d_ready;
    tl_opcode_t        d_opcode;
    logic [1:0]        d_param;
    tl_size_t          d_size;
    logic [SID_W-1:0]  d_source;
    logic [XLEN-1:0]   d_data;
    logic              d_corrupt;
    logic              d_denied;

    int     value_errors;   // Wrong field values
    int     other_errors;   // Timeouts, missing file
    int     requests;
    integer seed;           // Drives the d_ready stalls
    bit     hung;           // A wait loop ran out

    tlul_memory #(
        .MEM_BYTES (MEM_BYTES)
    ) dut0 (
        .clk       (clk),       .reset     (reset),
        .a_valid   (a_valid),   .a_ready   (a_ready),
        .a_opcode  (a_opcode),  .a_param   (a_param),
        .a_size    (a_size),    .a_source  (a_source),
        .a_address (a_address), .a_mask    (a_mask),
        .a_data    (a_data),
        .d_valid   (d_valid),   .d_ready   (d_ready),
        .d_opcode  (d_opcode),  .d_param   (d_param),
        .d_size    (d_size),    .d_source  (d_source),
        .d_data    (d_data),    .d_corrupt (d_corrupt),
        .d_denied  (d_denied)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;   // 10 ns period

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    ////////////////////////////////////////
    // A channel
    ////////////////////////////////////////
    task automatic send_request(input logic [2:0] op, input logic [2:0] size,
                                input logic [SID_W-1:0] source, input logic [XLEN-1:0] address,
                                input logic [STRB_W-1:0] mask, input logic [XLEN-1:0] data);
        int n;
        n = 0;
        @(negedge clk);
        while (!a_ready && n < TIMEOUT) begin   // Slave still busy
            @(negedge clk);
            n++;
        end
        if (!a_ready) begin
            other_errors++;
            hung = 1'b1;
            $display("Timeout: a_ready stayed low before request %0d", requests);
        end else begin
            @(posedge clk);
            a_valid   <= 1'b1;
            a_opcode  <= op;
            a_size    <= size;
            a_source  <= source;
            a_address <= address;
            a_mask    <= mask;
            a_data    <= data;
            n = 0;
            @(negedge clk);
            while (!(a_valid && a_ready) && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!(a_valid && a_ready)) begin
                other_errors++;
                hung = 1'b1;
                $display("Timeout: request %0d was never accepted on the A channel", requests);
            end
            @(posedge clk);                     // Handshake edge
            a_valid <= 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // D channel
    ////////////////////////////////////////
    task automatic take_response(input logic [2:0] exp_op, input logic exp_denied,
                                 input logic [XLEN-1:0] exp_data, input logic [2:0] exp_size,
                                 input logic [SID_W-1:0] exp_source);
        int n;
        bit got;
        n   = 0;
        got = 1'b0;
        while (!got && n < TIMEOUT) begin
            @(posedge clk);
            d_ready <= (($random(seed) % 3) != 0);   // Stall about a third of cycles
            @(negedge clk);
            if (d_valid) begin
                // Fields checked on every held cycle too
                check_value("a_ready", XLEN'(a_ready), '0);
                check_value("d_opcode", XLEN'(d_opcode), XLEN'(exp_op));
                check_value("d_param", XLEN'(d_param),
                            XLEN'(exp_denied ? PARAM_DENIED : PARAM_OK));
                check_value("d_size", XLEN'(d_size), XLEN'(exp_size));
                check_value("d_source", XLEN'(d_source), XLEN'(exp_source));
                check_value("d_data", d_data, exp_data);
                check_value("d_corrupt", XLEN'(d_corrupt), '0);
                check_value("d_denied", XLEN'(d_denied), XLEN'(exp_denied));
                got = d_ready;
            end
            n++;
        end
        @(posedge clk);
        d_ready <= 1'b0;
        if (!got) begin
            other_errors++;
            hung = 1'b1;
            $display("Timeout: no D channel response for request %0d", requests);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int                fd;
        int                fields;
        int                assert_fails;
        string             line;
        logic [2:0]        op;
        logic [2:0]        size;
        logic [2:0]        exp_op;
        logic [XLEN-1:0]   address;
        logic [XLEN-1:0]   data;
        logic [XLEN-1:0]   exp_data;
        logic [STRB_W-1:0] mask;
        logic              exp_denied;
        value_errors = 0;
        other_errors = 0;
        requests     = 0;
        hung         = 1'b0;
        seed         = 32'h0ca149a0;
        reset        = 1'b1;
        a_valid      = 1'b0;
        a_opcode     = OP_GET;
        a_param      = 3'd0;
        a_size       = SZ_BYTE;
        a_source     = '0;
        a_address    = '0;
        a_mask       = '0;
        a_data       = '0;
        d_ready      = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file %s", STIM_PATH);
        end else begin
            while (!hung && $fgets(line, fd) > 0) begin
                if (line.len() > 0 && line[0] != "#") begin   // Skip column notes
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h", op, size, address,
                                     mask, data, exp_op, exp_denied, exp_data);
                    if (fields == 8) begin
                        requests++;
                        send_request(op, size, SID_W'(requests), address, mask, data);
                        if (!hung) begin
                            take_response(exp_op, exp_denied, exp_data, size, SID_W'(requests));
                        end
                    end
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        assert_fails = dut0.u_assertions.fail_count;
        $display("Requests %0d, value errors %0d, other failures %0d, assertion failures %0d",
                 requests, value_errors, other_errors, assert_fails);
        if (value_errors == 0 && other_errors == 0 && assert_fails == 0 && requests > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tlul_memory_assertions.sv ====
////////////////////////////////////////
// TileLink-UL memory protocol assertions
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tlul_memory_assertions (
    input wire                                   clk,
    input wire                                   reset,
    input wire                                   a_valid,
    input wire                                   a_ready,
    input wire                                   d_valid,
    input wire                                   d_ready,
    input wire tlul_mem_pkg::tl_opcode_t         d_opcode,
    input wire [1:0]                             d_param,
    input wire tlul_mem_pkg::tl_size_t           d_size,
    input wire [tlul_mem_pkg::SID_W-1:0]         d_source,
    input wire [tlul_mem_pkg::XLEN-1:0]          d_data,
    input wire                                   d_denied
);

    int fail_count = 0;   // Failed assertion total

    // Stalled response must not move
    d_hold: assert property (@(posedge clk) disable iff (reset)
        d_valid && !d_ready |=> d_valid && $stable(d_opcode) && $stable(d_param) &&
            $stable(d_size) && $stable(d_source) && $stable(d_data) && $stable(d_denied))
        else begin
            fail_count++;
            $error("D channel fields changed while stalled");
        end

    // Registered two edges after acceptance and seen on the third sample
    a_to_d: assert property (@(posedge clk) disable iff (reset)
        a_valid && a_ready |-> ##3 $rose(d_valid))
        else begin
            fail_count++;
            $error("d_valid did not rise two cycles after acceptance");
        end

    // One request in flight
    one_busy: assert property (@(posedge clk) disable iff (reset)
        d_valid |-> !a_ready)
        else begin
            fail_count++;
            $error("a_ready high while a response is pending");
        end

endmodule

bind tlul_memory tlul_memory_assertions u_assertions (
    .clk      (clk),      .reset    (reset),
    .a_valid  (a_valid),  .a_ready  (a_ready),
    .d_valid  (d_valid),  .d_ready  (d_ready),
    .d_opcode (d_opcode), .d_param  (d_param),
    .d_size   (d_size),   .d_source (d_source),
    .d_data   (d_data),   .d_denied (d_denied)
);

`default_nettype wire

// ==== logic/tlul_memory.sv ====
////////////////////////////////////////
// TileLink-UL slave memory, top level
// Decode, execute and result stages
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tlul_memory #(
    parameter int MEM_BYTES = 1024
) (
    input  wire                                  clk,
    input  wire                                  reset,

    // A channel
    input  wire                                  a_valid,
    output logic                                 a_ready,
    input  wire tlul_mem_pkg::tl_opcode_t        a_opcode,
    input  wire [2:0]                            a_param,    // Not used by this slave
    input  wire tlul_mem_pkg::tl_size_t          a_size,
    input  wire [tlul_mem_pkg::SID_W-1:0]        a_source,
    input  wire [tlul_mem_pkg::XLEN-1:0]         a_address,
    input  wire [tlul_mem_pkg::STRB_W-1:0]       a_mask,
    input  wire [tlul_mem_pkg::XLEN-1:0]         a_data,

    // D channel
    output logic                                 d_valid,
    input  wire                                  d_ready,
    output tlul_mem_pkg::tl_opcode_t             d_opcode,
    output logic [1:0]                           d_param,
    output tlul_mem_pkg::tl_size_t               d_size,
    output logic [tlul_mem_pkg::SID_W-1:0]       d_source,
    output logic [tlul_mem_pkg::XLEN-1:0]        d_data,
    output logic                                 d_corrupt,
    output logic                                 d_denied
);

    import tlul_mem_pkg::*;

    ////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////
    logic             req_valid;
    logic             req_read;
    tl_size_t         req_size;
    logic [SID_W-1:0] req_source;
    logic [XLEN-1:0]  req_address;
    logic [XLEN-1:0]  req_data;
    logic             req_denied;

    logic             exec_valid;
    logic             exec_read;
    logic             exec_denied;
    tl_size_t         exec_size;
    logic [SID_W-1:0] exec_source;
    logic [XLEN-1:0]  exec_data;

    logic             resp_done;   // Releases decode for the next request

    tlul_request_decode #(
        .MEM_BYTES (MEM_BYTES)
    ) u_decode (
        .clk         (clk),
        .reset       (reset),
        .a_valid     (a_valid),
        .a_ready     (a_ready),
        .a_opcode    (a_opcode),
        .a_size      (a_size),
        .a_source    (a_source),
        .a_address   (a_address),
        .a_mask      (a_mask),
        .a_data      (a_data),
        .resp_done   (resp_done),
        .req_valid   (req_valid),
        .req_read    (req_read),
        .req_size    (req_size),
        .req_source  (req_source),
        .req_address (req_address),
        .req_data    (req_data),
        .req_denied  (req_denied)
    );

    tlul_mem_array #(
        .MEM_BYTES (MEM_BYTES)
    ) u_array (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_read    (req_read),
        .req_size    (req_size),
        .req_source  (req_source),
        .req_address (req_address),
        .req_data    (req_data),
        .req_denied  (req_denied),
        .exec_valid  (exec_valid),
        .exec_read   (exec_read),
        .exec_denied (exec_denied),
        .exec_size   (exec_size),
        .exec_source (exec_source),
        .exec_data   (exec_data)
    );

    tlul_response_gen u_response (
        .clk         (clk),
        .reset       (reset),
        .exec_valid  (exec_valid),
        .exec_read   (exec_read),
        .exec_denied (exec_denied),
        .exec_size   (exec_size),
        .exec_source (exec_source),
        .exec_data   (exec_data),
        .d_valid     (d_valid),
        .d_ready     (d_ready),
        .d_opcode    (d_opcode),
        .d_param     (d_param),
        .d_size      (d_size),
        .d_source    (d_source),
        .d_data      (d_data),
        .d_corrupt   (d_corrupt),
        .d_denied    (d_denied),
        .resp_done   (resp_done)
    );

endmodule

`default_nettype wire

// ==== logic/tlul_response_gen.sv ====
////////////////////////////////////////
// D-channel response stage
// Holds the response until the receiver takes it
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tlul_response_gen (
    input  wire                                  clk,
    input  wire                                  reset,

    // From execute stage
    input  wire                                  exec_valid,
    input  wire                                  exec_read,
    input  wire                                  exec_denied,
    input  wire tlul_mem_pkg::tl_size_t          exec_size,
    input  wire [tlul_mem_pkg::SID_W-1:0]        exec_source,
    input  wire [tlul_mem_pkg::XLEN-1:0]         exec_data,

    // D channel
    output logic                                 d_valid,
    input  wire                                  d_ready,
    output tlul_mem_pkg::tl_opcode_t             d_opcode,
    output logic [1:0]                           d_param,
    output tlul_mem_pkg::tl_size_t               d_size,
    output logic [tlul_mem_pkg::SID_W-1:0]       d_source,
    output logic [tlul_mem_pkg::XLEN-1:0]        d_data,
    output logic                                 d_corrupt,
    output logic                                 d_denied,

    // Back to decode stage
    output logic                                 resp_done
);

    import tlul_mem_pkg::*;

    tl_opcode_t resp_opcode;
    logic [1:0] resp_param;

    // Handshake completes this cycle
    assign resp_done = d_valid && d_ready;

    // No corrupt responses from this memory
    assign d_corrupt = 1'b0;

    // Opcode and param from the outcome
    always_comb begin
        if (exec_denied) begin
            resp_opcode = OP_ACK_ERROR;
            resp_param  = PARAM_DENIED;
        end else if (exec_read) begin
            resp_opcode = OP_ACK_DATA;
            resp_param  = PARAM_OK;
        end else begin
            resp_opcode = OP_ACK;
            resp_param  = PARAM_OK;
        end
    end

    ////////////////////////////////////////
    // D-channel registers
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_valid  <= 1'b0;
            d_opcode <= OP_ACK;
            d_param  <= PARAM_OK;
            d_size   <= SZ_BYTE;
            d_source <= '0;
            d_data   <= '0;
            d_denied <= 1'b0;
        end else if (exec_valid) begin
            // New response held until taken
            d_valid  <= 1'b1;
            d_opcode <= resp_opcode;
            d_param  <= resp_param;
            d_size   <= exec_size;      // Echo request
            d_source <= exec_source;
            d_data   <= exec_data;
            d_denied <= exec_denied;
        end else if (resp_done) begin
            d_valid  <= 1'b0;           // Cleared once taken
            d_opcode <= OP_ACK;
            d_param  <= PARAM_OK;
            d_size   <= SZ_BYTE;
            d_source <= '0;
            d_data   <= '0;
            d_denied <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlul_mem_array.sv ====
////////////////////////////////////////
// Execute stage
// Byte array performing validated reads and writes
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tlul_mem_array #(
    parameter int MEM_BYTES = 1024
) (
    input  wire                                  clk,
    input  wire                                  reset,

    // From decode stage
    input  wire                                  req_valid,
    input  wire                                  req_read,
    input  wire tlul_mem_pkg::tl_size_t          req_size,
    input  wire [tlul_mem_pkg::SID_W-1:0]        req_source,
    input  wire [tlul_mem_pkg::XLEN-1:0]         req_address,
    input  wire [tlul_mem_pkg::XLEN-1:0]         req_data,
    input  wire                                  req_denied,

    // To result stage
    output logic                                 exec_valid,
    output logic                                 exec_read,
    output logic                                 exec_denied,
    output tlul_mem_pkg::tl_size_t               exec_size,
    output logic [tlul_mem_pkg::SID_W-1:0]       exec_source,
    output logic [tlul_mem_pkg::XLEN-1:0]        exec_data
);

    import tlul_mem_pkg::*;

    localparam int AW = $clog2(MEM_BYTES);   // Byte index width

    logic [7:0]      mem [MEM_BYTES];         // Byte storage

    logic [AW-1:0]   idx0;                    // Most significant byte of the access
    logic [AW-1:0]   idx1;
    logic [AW-1:0]   idx2;
    logic [AW-1:0]   idx3;
    logic            wr_en;
    logic [XLEN-1:0] rd_data;

    // Only the low bits matter once the range check passed
    assign idx0 = req_address[AW-1:0];
    assign idx1 = idx0 + AW'(1);
    assign idx2 = idx0 + AW'(2);
    assign idx3 = idx0 + AW'(3);

    assign wr_en = req_valid && !req_read && !req_denied;

    ////////////////////////////////////////
    // Read assembly
    ////////////////////////////////////////
    // Lowest address lands in the most significant used byte
    always_comb begin
        case (req_size)
            SZ_BYTE: rd_data = {{(XLEN-8){1'b0}}, mem[idx0]};
            SZ_HALF: rd_data = {{(XLEN-16){1'b0}}, mem[idx0], mem[idx1]};
            SZ_WORD: rd_data = {mem[idx0], mem[idx1], mem[idx2], mem[idx3]};
            default: rd_data = '0;
        endcase
    end

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (req_size)
                SZ_BYTE: begin
                    mem[idx0] <= req_data[7:0];
                end
                SZ_HALF: begin
                    mem[idx0] <= req_data[15:8];
                    mem[idx1] <= req_data[7:0];
                end
                SZ_WORD: begin
                    mem[idx0] <= req_data[31:24];
                    mem[idx1] <= req_data[23:16];
                    mem[idx2] <= req_data[15:8];
                    mem[idx3] <= req_data[7:0];
                end
                default: begin
                    // Oversize is denied upstream
                end
            endcase
        end
    end

    // Stage strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= req_valid;   // Pulse follows request by one cycle
        end
    end

    // Sideband and result data
    always_ff @(posedge clk) begin
        if (req_valid) begin
            exec_read   <= req_read;
            exec_denied <= req_denied;
            exec_size   <= req_size;
            exec_source <= req_source;
            exec_data   <= (req_read && !req_denied) ? rd_data : '0;   // Zero for writes and errors
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlul_request_decode.sv ====
////////////////////////////////////////
// A-channel request decode
// Accepts, captures and validates one request
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tlul_request_decode #(
    parameter int MEM_BYTES = 1024
) (
    input  wire                                  clk,
    input  wire                                  reset,

    // A channel
    input  wire                                  a_valid,
    output logic                                 a_ready,
    input  wire tlul_mem_pkg::tl_opcode_t        a_opcode,
    input  wire tlul_mem_pkg::tl_size_t          a_size,
    input  wire [tlul_mem_pkg::SID_W-1:0]        a_source,
    input  wire [tlul_mem_pkg::XLEN-1:0]         a_address,
    input  wire [tlul_mem_pkg::STRB_W-1:0]       a_mask,
    input  wire [tlul_mem_pkg::XLEN-1:0]         a_data,

    // From result stage
    input  wire                                  resp_done,

    // To execute stage
    output logic                                 req_valid,
    output logic                                 req_read,
    output tlul_mem_pkg::tl_size_t               req_size,
    output logic [tlul_mem_pkg::SID_W-1:0]       req_source,
    output logic [tlul_mem_pkg::XLEN-1:0]        req_address,
    output logic [tlul_mem_pkg::XLEN-1:0]        req_data,
    output logic                                 req_denied
);

    import tlul_mem_pkg::*;

    localparam int CNT_W = $clog2(STRB_W + 1);   // Enough for a full mask count

    logic             busy;        // Request in flight until D handshake
    logic             accept;      // A handshake this cycle
    logic             is_read;
    logic [XLEN-1:0]  n_bytes;     // Access byte count
    logic [CNT_W-1:0] mask_ones;
    logic             size_bad;
    logic             range_bad;
    logic             mask_bad;

    // Population count of the write mask
    function automatic logic [CNT_W-1:0] count_ones(input logic [STRB_W-1:0] bits);
        logic [CNT_W-1:0] total;
        total = '0;
        for (int k = 0; k < STRB_W; k++) begin
            total = total + CNT_W'(bits[k]);
        end
        return total;
    endfunction

    assign a_ready = ~busy;
    assign accept  = a_valid && a_ready;
    assign is_read = (a_opcode == OP_GET);   // Anything else is a write

    ////////////////////////////////////////
    // Request checks
    ////////////////////////////////////////
    always_comb begin
        case (a_size)
            SZ_BYTE: n_bytes = XLEN'(1);
            SZ_HALF: n_bytes = XLEN'(2);
            default: n_bytes = XLEN'(STRB_W);   // Word or oversize
        endcase
        mask_ones = count_ones(a_mask);
        size_bad  = (a_size > SZ_WORD);
        // Last byte of the access must land inside the array
        range_bad = (a_address > (XLEN'(MEM_BYTES) - n_bytes));
        case (a_size)
            SZ_BYTE: mask_bad = (mask_ones != CNT_W'(1));
            SZ_HALF: mask_bad = (mask_ones != CNT_W'(2)) ||
                                !((a_mask[1:0] == 2'b11) || (a_mask[3:2] == 2'b11));
            SZ_WORD: mask_bad = (mask_ones != CNT_W'(STRB_W));
            default: mask_bad = 1'b1;
        endcase
    end

    // Busy flag and request strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;                 // One-cycle pulse after acceptance
            if (accept) begin
                busy <= 1'b1;
            end else if (resp_done) begin
                busy <= 1'b0;                    // Free after D handshake
            end
        end
    end

    // Captured request fields
    always_ff @(posedge clk) begin
        if (accept) begin
            req_read    <= is_read;
            req_size    <= a_size;
            req_source  <= a_source;
            req_address <= a_address;
            req_data    <= a_data;
            req_denied  <= size_bad || range_bad || (!is_read && mask_bad); // Reads skip mask
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlul_mem_pkg.sv ====
////////////////////////////////////////
// TileLink-UL memory shared definitions
// Bus widths, opcodes, sizes, D params
////////////////////////////////////////
`default_nettype none

package tlul_mem_pkg;

    ////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////
    localparam int XLEN   = 32;          // Data and address width
    localparam int STRB_W = XLEN / 8;    // One mask bit per byte lane
    localparam int SID_W  = 2;           // Source ID width

    // Opcode field of both channels
    typedef logic [2:0] tl_opcode_t;

    // Size field as log2 of byte count
    typedef logic [2:0] tl_size_t;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////
    // A channel
    localparam tl_opcode_t OP_GET       = 3'd4;
    localparam tl_opcode_t OP_PUT_FULL  = 3'd0;

    // D channel
    localparam tl_opcode_t OP_ACK       = 3'd0;
    localparam tl_opcode_t OP_ACK_DATA  = 3'd2;
    localparam tl_opcode_t OP_ACK_ERROR = 3'd7;   // Denied access response

    ////////////////////////////////////////
    // Size codes
    ////////////////////////////////////////
    localparam tl_size_t SZ_BYTE = 3'd0;   // 1 byte
    localparam tl_size_t SZ_HALF = 3'd1;   // 2 bytes
    localparam tl_size_t SZ_WORD = 3'd2;   // 4 bytes is the largest size

    // D channel param
    localparam logic [1:0] PARAM_OK     = 2'd0;
    localparam logic [1:0] PARAM_DENIED = 2'd2;

endpackage

`default_nettype wire
